// ==== design/mem_region_pkg.sv ====
// shared widths, region constants and types for the data-memory region RTL and its testbench
package mem_region_pkg;

  // data widths
  localparam int WORD_W = 32;
  localparam int WIDE_W = 64;

  // local data RAM geometry
  localparam int RAM_BYTES   = 32768;
  localparam int RAM_ADDR_W  = $clog2(RAM_BYTES);
  localparam int RAM_WORDS_W = RAM_ADDR_W - $clog2(WIDE_W / 8);

  // address decode, top bits compared against the local RAM region
  localparam int                  REGION_W   = 12;
  localparam logic [REGION_W-1:0] RAM_REGION = 12'h001;

  // core side vectors
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [WORD_W/8-1:0]   be_t;

  // RAM and loader side vectors
  typedef logic [WIDE_W-1:0]     wide_t;
  typedef logic [WIDE_W/8-1:0]   wide_be_t;

  // addressing inside the RAM
  typedef logic [RAM_ADDR_W-1:0]  ram_addr_t;
  typedef logic [RAM_WORDS_W-1:0] ram_word_t;

  // which target owes the next core response
  typedef enum logic {
    RESP_EXT = 1'b0,
    RESP_RAM = 1'b1
  } resp_src_e;

endpackage

// ==== design/sp_ram.sv ====
// single-port 64-bit data RAM with byte enables and registered read, write cycles return the new word
`timescale 1ns/1ps

module sp_ram (
  input  logic                      clk,
  input  logic                      en_i,
  input  mem_region_pkg::ram_word_t word_i,
  input  logic                      we_i,
  input  mem_region_pkg::wide_be_t  be_i,
  input  mem_region_pkg::wide_t     wdata_i,
  output mem_region_pkg::wide_t     rdata_o
);

  import mem_region_pkg::*;

  wide_t mem_q [2**RAM_WORDS_W];
  wide_t cur_word;
  wide_t next_word;

  assign cur_word = mem_q[word_i];

  // merge write data into the stored word byte by byte
  always_comb begin
    next_word = cur_word;
    if (we_i) begin
      for (int b = 0; b < WIDE_W / 8; b++) begin
        if (be_i[b]) begin
          next_word[8*b +: 8] = wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[word_i] <= next_word;
      end
      rdata_o <= next_word;
    end
  end

endmodule

// ==== design/ram_mux.sv ====
// fixed-priority mux of the 64-bit loader port and the 32-bit core port onto one data RAM port
`timescale 1ns/1ps

module ram_mux (
  input  logic                      clk,
  input  logic                      rst_n,

  // wide loader port, never stalled
  input  logic                      load_req_i,
  input  mem_region_pkg::ram_word_t load_word_i,
  input  logic                      load_we_i,
  input  mem_region_pkg::wide_be_t  load_be_i,
  input  mem_region_pkg::wide_t     load_wdata_i,
  output mem_region_pkg::wide_t     load_rdata_o,

  // 32-bit core port
  input  logic                      core_req_i,
  input  mem_region_pkg::ram_addr_t core_addr_i,
  input  logic                      core_we_i,
  input  mem_region_pkg::be_t       core_be_i,
  input  mem_region_pkg::word_t     core_wdata_i,
  output logic                      core_gnt_o,
  output logic                      core_rvalid_o,
  output mem_region_pkg::word_t     core_rdata_o,

  // RAM side
  output logic                      ram_en_o,
  output mem_region_pkg::ram_word_t ram_word_o,
  output logic                      ram_we_o,
  output mem_region_pkg::wide_be_t  ram_be_o,
  output mem_region_pkg::wide_t     ram_wdata_o,
  input  mem_region_pkg::wide_t     ram_rdata_i
);

  import mem_region_pkg::*;

  // core access mapped onto a 64-bit RAM word
  ram_word_t core_word;
  logic      core_lane;
  wide_be_t  core_wide_be;
  wide_t     core_wide_wdata;

  // state of the core access in flight
  logic      rvalid_q;
  logic      lane_q;

  // word index and lane from the byte address
  assign core_word = core_addr_i[RAM_ADDR_W-1 -: RAM_WORDS_W];
  assign core_lane = core_addr_i[2];

  // place the 32-bit access into its half of the wide word
  always_comb begin
    if (core_lane) begin
      core_wide_be = {core_be_i, {(WORD_W/8){1'b0}}};
    end else begin
      core_wide_be = {{(WORD_W/8){1'b0}}, core_be_i};
    end
  end

  // data is copied into both halves, the byte enables pick the lane
  assign core_wide_wdata = {core_wdata_i, core_wdata_i};

  // loader always owns the port while it requests
  assign core_gnt_o = core_req_i & ~load_req_i;

  always_comb begin
    if (load_req_i) begin
      ram_en_o    = 1'b1;
      ram_word_o  = load_word_i;
      ram_we_o    = load_we_i;
      ram_be_o    = load_be_i;
      ram_wdata_o = load_wdata_i;
    end else begin
      ram_en_o    = core_req_i;
      ram_word_o  = core_word;
      ram_we_o    = core_we_i;
      ram_be_o    = core_wide_be;
      ram_wdata_o = core_wide_wdata;
    end
  end

  // one cycle read latency, so rvalid follows grant directly
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      lane_q   <= 1'b0;
    end else begin
      rvalid_q <= core_gnt_o;
      if (core_gnt_o) begin
        lane_q <= core_lane;
      end
    end
  end

  assign core_rvalid_o = rvalid_q;

  // core gets its half of the word read last cycle
  always_comb begin
    if (lane_q) begin
      core_rdata_o = ram_rdata_i[WIDE_W-1:WORD_W];
    end else begin
      core_rdata_o = ram_rdata_i[WORD_W-1:0];
    end
  end

  // loader has no strobe, data is valid the cycle after its request
  assign load_rdata_o = ram_rdata_i;

endmodule

// ==== design/lsu_demux.sv ====
// address demux of the load/store port onto local RAM or external bus, with in-order response return
`timescale 1ns/1ps

module lsu_demux (
  input  logic                      clk,
  input  logic                      rst_n,

  // load/store port
  input  logic                      core_req_i,
  input  mem_region_pkg::word_t     core_addr_i,
  input  logic                      core_we_i,
  input  mem_region_pkg::be_t       core_be_i,
  input  mem_region_pkg::word_t     core_wdata_i,
  output logic                      core_gnt_o,
  output logic                      core_rvalid_o,
  output mem_region_pkg::word_t     core_rdata_o,

  // external bus target
  output logic                      ext_req_o,
  output mem_region_pkg::word_t     ext_addr_o,
  output logic                      ext_we_o,
  output mem_region_pkg::be_t       ext_be_o,
  output mem_region_pkg::word_t     ext_wdata_o,
  input  logic                      ext_gnt_i,
  input  logic                      ext_rvalid_i,
  input  mem_region_pkg::word_t     ext_rdata_i,

  // local RAM target
  output logic                      ram_req_o,
  output mem_region_pkg::ram_addr_t ram_addr_o,
  output logic                      ram_we_o,
  output mem_region_pkg::be_t       ram_be_o,
  output mem_region_pkg::word_t     ram_wdata_o,
  input  logic                      ram_gnt_i,
  input  logic                      ram_rvalid_i,
  input  mem_region_pkg::word_t     ram_rdata_i
);

  import mem_region_pkg::*;

  logic      is_ram_addr;
  resp_src_e resp_src_q;
  resp_src_e resp_src_d;

  // region decode on the top address bits
  assign is_ram_addr = (core_addr_i[WORD_W-1 -: REGION_W] == RAM_REGION);

  assign ram_req_o   = core_req_i & is_ram_addr;
  assign ext_req_o   = core_req_i & ~is_ram_addr;

  // request fields go to both targets, only one sees req
  assign ram_addr_o  = core_addr_i[RAM_ADDR_W-1:0];
  assign ram_we_o    = core_we_i;
  assign ram_be_o    = core_be_i;
  assign ram_wdata_o = core_wdata_i;

  assign ext_addr_o  = core_addr_i;
  assign ext_we_o    = core_we_i;
  assign ext_be_o    = core_be_i;
  assign ext_wdata_o = core_wdata_i;

  // grant from the selected target, remember who answers next
  always_comb begin
    resp_src_d = resp_src_q;
    core_gnt_o = 1'b0;
    if (ext_req_o) begin
      core_gnt_o = ext_gnt_i;
      if (ext_gnt_i) begin
        resp_src_d = RESP_EXT;
      end
    end else if (ram_req_o) begin
      core_gnt_o = ram_gnt_i;
      if (ram_gnt_i) begin
        resp_src_d = RESP_RAM;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= RESP_RAM;
    end else begin
      resp_src_q <= resp_src_d;
    end
  end

  // responses come back in order so one owner at a time
  assign core_rvalid_o = ram_rvalid_i | ext_rvalid_i;
  assign core_rdata_o  = (resp_src_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;

endmodule

// ==== design/lsu_mem_region.sv ====
// top of the data-memory region, load/store port split between local data RAM and external bus
`timescale 1ns/1ps

module lsu_mem_region (
  input  logic                     clk,
  input  logic                     rst_n,

  // load/store port from the core
  input  logic                     core_req_i,
  input  mem_region_pkg::word_t    core_addr_i,
  input  logic                     core_we_i,
  input  mem_region_pkg::be_t      core_be_i,
  input  mem_region_pkg::word_t    core_wdata_i,
  output logic                     core_gnt_o,
  output logic                     core_rvalid_o,
  output mem_region_pkg::word_t    core_rdata_o,

  // external bus port
  output logic                     ext_req_o,
  output mem_region_pkg::word_t    ext_addr_o,
  output logic                     ext_we_o,
  output mem_region_pkg::be_t      ext_be_o,
  output mem_region_pkg::word_t    ext_wdata_o,
  input  logic                     ext_gnt_i,
  input  logic                     ext_rvalid_i,
  input  mem_region_pkg::word_t    ext_rdata_i,

  // wide loader port, always has priority on the RAM
  input  logic                     load_req_i,
  input  mem_region_pkg::ram_word_t load_word_i,
  input  logic                     load_we_i,
  input  mem_region_pkg::wide_be_t load_be_i,
  input  mem_region_pkg::wide_t    load_wdata_i,
  output mem_region_pkg::wide_t    load_rdata_o
);

  import mem_region_pkg::*;

  // demux to RAM multiplexer
  logic      ram_req;
  ram_addr_t ram_addr;
  logic      ram_we;
  be_t       ram_be;
  word_t     ram_wdata;
  logic      ram_gnt;
  logic      ram_rvalid;
  word_t     ram_rdata;

  // RAM multiplexer to data RAM
  logic      mem_en;
  ram_word_t mem_word;
  logic      mem_we;
  wide_be_t  mem_be;
  wide_t     mem_wdata;
  wide_t     mem_rdata;

  lsu_demux u_lsu_demux (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .core_req_i    ( core_req_i    ),
    .core_addr_i   ( core_addr_i   ),
    .core_we_i     ( core_we_i     ),
    .core_be_i     ( core_be_i     ),
    .core_wdata_i  ( core_wdata_i  ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .ext_req_o     ( ext_req_o     ),
    .ext_addr_o    ( ext_addr_o    ),
    .ext_we_o      ( ext_we_o      ),
    .ext_be_o      ( ext_be_o      ),
    .ext_wdata_o   ( ext_wdata_o   ),
    .ext_gnt_i     ( ext_gnt_i     ),
    .ext_rvalid_i  ( ext_rvalid_i  ),
    .ext_rdata_i   ( ext_rdata_i   ),
    .ram_req_o     ( ram_req       ),
    .ram_addr_o    ( ram_addr      ),
    .ram_we_o      ( ram_we        ),
    .ram_be_o      ( ram_be        ),
    .ram_wdata_o   ( ram_wdata     ),
    .ram_gnt_i     ( ram_gnt       ),
    .ram_rvalid_i  ( ram_rvalid    ),
    .ram_rdata_i   ( ram_rdata     )
  );

  ram_mux u_ram_mux (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .load_req_i    ( load_req_i    ),
    .load_word_i   ( load_word_i   ),
    .load_we_i     ( load_we_i     ),
    .load_be_i     ( load_be_i     ),
    .load_wdata_i  ( load_wdata_i  ),
    .load_rdata_o  ( load_rdata_o  ),
    .core_req_i    ( ram_req       ),
    .core_addr_i   ( ram_addr      ),
    .core_we_i     ( ram_we        ),
    .core_be_i     ( ram_be        ),
    .core_wdata_i  ( ram_wdata     ),
    .core_gnt_o    ( ram_gnt       ),
    .core_rvalid_o ( ram_rvalid    ),
    .core_rdata_o  ( ram_rdata     ),
    .ram_en_o      ( mem_en        ),
    .ram_word_o    ( mem_word      ),
    .ram_we_o      ( mem_we        ),
    .ram_be_o      ( mem_be        ),
    .ram_wdata_o   ( mem_wdata     ),
    .ram_rdata_i   ( mem_rdata     )
  );

  // 32 KiB local data RAM
  sp_ram u_sp_ram (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .word_i  ( mem_word  ),
    .we_i    ( mem_we    ),
    .be_i    ( mem_be    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

// ==== tb/lsu_mem_region_chk.sv ====
// concurrent protocol checks, bound into the RAM multiplexer and the address demux
`timescale 1ns/1ps

module lsu_mem_region_chk (
  input logic clk,
  input logic rst_n,
  input logic core_gnt_i,
  input logic core_rvalid_i,
  input logic load_req_i,
  input logic ram_req_i,
  input logic ext_req_i
);

  // RAM access answers exactly one cycle after its grant
  gnt_then_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    core_gnt_i |=> core_rvalid_i)
    else $error("core rvalid missing one cycle after grant");

  rvalid_needs_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    core_rvalid_i |-> $past(core_gnt_i))
    else $error("core rvalid without a grant in the cycle before");

  // loader owns the port while it requests
  no_gnt_under_load: assert property (@(posedge clk) disable iff (!rst_n)
    load_req_i |-> !core_gnt_i)
    else $error("core grant while the loader requests");

  one_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_req_i && ext_req_i))
    else $error("RAM and external requests at the same time");

endmodule

bind ram_mux lsu_mem_region_chk u_mux_chk (
  .clk           ( clk           ),
  .rst_n         ( rst_n         ),
  .core_gnt_i    ( core_gnt_o    ),
  .core_rvalid_i ( core_rvalid_o ),
  .load_req_i    ( load_req_i    ),
  .ram_req_i     ( 1'b0          ),
  .ext_req_i     ( 1'b0          )
);

bind lsu_demux lsu_mem_region_chk u_demux_chk (
  .clk           ( clk           ),
  .rst_n         ( rst_n         ),
  .core_gnt_i    ( 1'b0          ),
  .core_rvalid_i ( 1'b0          ),
  .load_req_i    ( 1'b0          ),
  .ram_req_i     ( ram_req_o     ),
  .ext_req_i     ( ext_req_o     )
);

// ==== tb/tb_lsu_mem_region.sv ====
// testbench for the data-memory region, random core, loader and external traffic checked against models
`timescale 1ns/1ps

module tb_lsu_mem_region;

  import mem_region_pkg::*;

  localparam int unsigned SEED      = 32'h4350_699b;
  localparam int          N_TRANS   = 600;
  localparam int          MAX_CYC   = 20000;
  localparam int          WAIT_CYC  = 20;
  localparam word_t       EXT_XOR   = 32'hA5A5_5A5A;

  logic      clk;
  logic      rst_n;
  logic      core_req;
  word_t     core_addr;
  logic      core_we;
  be_t       core_be;
  word_t     core_wdata;
  logic      core_gnt;
  logic      core_rvalid;
  word_t     core_rdata;
  logic      ext_req;
  word_t     ext_addr;
  logic      ext_we;
  be_t       ext_be;
  word_t     ext_wdata;
  logic      ext_gnt;
  logic      ext_rvalid;
  word_t     ext_rdata;
  logic      load_req;
  ram_word_t load_word;
  logic      load_we;
  wide_be_t  load_be;
  wide_t     load_wdata;
  wide_t     load_rdata;

  // byte model of the data RAM
  logic [7:0] ram_model [RAM_BYTES];

  // responses owed to the core in arrival order
  bit    exp_is_ram  [$];
  bit    exp_is_read [$];
  word_t exp_data    [$];
  int    exp_cyc     [$];

  int    cyc;
  int    n_done;
  int    load_left;
  bit    last_gnt;
  bit    ext_open;
  bit    load_chk;
  wide_t load_exp;

  // external slave model state
  bit    slv_busy;
  int    slv_gnt_wait;
  int    slv_resp_wait;
  word_t slv_rdata;

  lsu_mem_region u_dut (
    .clk           ( clk         ),
    .rst_n         ( rst_n       ),
    .core_req_i    ( core_req    ),
    .core_addr_i   ( core_addr   ),
    .core_we_i     ( core_we     ),
    .core_be_i     ( core_be     ),
    .core_wdata_i  ( core_wdata  ),
    .core_gnt_o    ( core_gnt    ),
    .core_rvalid_o ( core_rvalid ),
    .core_rdata_o  ( core_rdata  ),
    .ext_req_o     ( ext_req     ),
    .ext_addr_o    ( ext_addr    ),
    .ext_we_o      ( ext_we      ),
    .ext_be_o      ( ext_be      ),
    .ext_wdata_o   ( ext_wdata   ),
    .ext_gnt_i     ( ext_gnt     ),
    .ext_rvalid_i  ( ext_rvalid  ),
    .ext_rdata_i   ( ext_rdata   ),
    .load_req_i    ( load_req    ),
    .load_word_i   ( load_word   ),
    .load_we_i     ( load_we     ),
    .load_be_i     ( load_be     ),
    .load_wdata_i  ( load_wdata  ),
    .load_rdata_o  ( load_rdata  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_mismatch(string sig, logic [63:0] got, logic [63:0] exp);
    $display("ERR %s got 0x%h expected 0x%h", sig, got, exp);
    stop_with_failure();
  endtask

  task automatic fail_with_reason(string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  function automatic wide_t model_word(ram_word_t w);
    wide_t d;
    for (int b = 0; b < WIDE_W / 8; b++) begin
      d[8*b +: 8] = ram_model[{w, 3'(b)}];
    end
    return d;
  endfunction

  // whole word index in every 16-bit slice
  function automatic wide_t fill_word(ram_word_t w);
    return {4'hA, w, 4'h5, w, 4'hC, w, 4'h3, w};
  endfunction

  // slave strobes are set first and the outputs checked once settled
  task automatic run_cycle();
    logic exp_ext;
    logic exp_gnt;
    ext_gnt    = !slv_busy && (slv_gnt_wait == 0);
    ext_rvalid = slv_busy && (slv_resp_wait == 0);
    ext_rdata  = ext_rvalid ? slv_rdata : $urandom;
    #1;
    exp_ext = core_req && (core_addr[WORD_W-1 -: REGION_W] != RAM_REGION);
    assert (ext_req === exp_ext) else value_mismatch("ext_req_o", 64'(ext_req), 64'(exp_ext));
    if (exp_ext) begin
      assert (ext_addr === core_addr) else
        value_mismatch("ext_addr_o", 64'(ext_addr), 64'(core_addr));
      assert (ext_we === core_we) else value_mismatch("ext_we_o", 64'(ext_we), 64'(core_we));
      assert (ext_be === core_be) else value_mismatch("ext_be_o", 64'(ext_be), 64'(core_be));
      assert (ext_wdata === core_wdata) else
        value_mismatch("ext_wdata_o", 64'(ext_wdata), 64'(core_wdata));
    end
    // external grant passes through, the loader only blocks RAM requests
    exp_gnt = core_req && (exp_ext ? ext_gnt : !load_req);
    assert (core_gnt === exp_gnt) else
      value_mismatch("core_gnt_o", 64'(core_gnt), 64'(exp_gnt));
    // loader data answers the access of the previous cycle
    if (load_chk) begin
      assert (load_rdata === load_exp) else
        value_mismatch("load_rdata_o", 64'(load_rdata), 64'(load_exp));
    end
    load_chk = 1'b0;
    if (core_rvalid === 1'b1) begin
      assert (exp_is_ram.size() != 0) else fail_with_reason("core response with no access open");
      assert (!exp_is_ram[0] || exp_cyc[0] == cyc - 1) else
        fail_with_reason("RAM response not one cycle after its grant");
      if (exp_is_read[0]) begin
        assert (core_rdata === exp_data[0]) else
          value_mismatch("core_rdata_o", 64'(core_rdata), 64'(exp_data[0]));
      end
      if (!exp_is_ram[0]) ext_open = 1'b0;
      void'(exp_is_ram.pop_front());
      void'(exp_is_read.pop_front());
      void'(exp_data.pop_front());
      void'(exp_cyc.pop_front());
      n_done++;
    end else begin
      assert (exp_is_ram.size() == 0 || !exp_is_ram[0]) else
        fail_with_reason("RAM response missing one cycle after its grant");
    end
    // accepted core request
    last_gnt = core_req && core_gnt;
    if (last_gnt) begin
      exp_is_ram.push_back(!exp_ext);
      exp_is_read.push_back(!core_we);
      exp_cyc.push_back(cyc);
      if (exp_ext) begin
        exp_data.push_back(core_addr ^ EXT_XOR);
        ext_open = 1'b1;
      end else begin
        exp_data.push_back({ram_model[{core_addr[RAM_ADDR_W-1:2], 2'd3}],
                            ram_model[{core_addr[RAM_ADDR_W-1:2], 2'd2}],
                            ram_model[{core_addr[RAM_ADDR_W-1:2], 2'd1}],
                            ram_model[{core_addr[RAM_ADDR_W-1:2], 2'd0}]});
        for (int i = 0; i < WORD_W / 8; i++) begin
          if (core_we && core_be[i]) begin
            ram_model[{core_addr[RAM_ADDR_W-1:2], 2'(i)}] = core_wdata[8*i +: 8];
          end
        end
      end
    end
    if (load_req) begin
      for (int i = 0; i < WIDE_W / 8; i++) begin
        if (load_we && load_be[i]) ram_model[{load_word, 3'(i)}] = load_wdata[8*i +: 8];
      end
      load_exp = model_word(load_word);
      load_chk = 1'b1;
    end
    // slave grants after 0 to 3 cycles and answers 1 to 3 cycles later
    if (ext_rvalid) begin
      slv_busy     = 1'b0;
      slv_gnt_wait = $urandom_range(0, 3);
    end else if (slv_busy) begin
      slv_resp_wait--;
    end
    if (ext_req && ext_gnt) begin
      slv_busy      = 1'b1;
      slv_rdata     = ext_addr ^ EXT_XOR;
      slv_resp_wait = $urandom_range(0, 2);
    end else if (ext_req && slv_gnt_wait > 0) begin
      slv_gnt_wait--;
    end
    cyc++;
    @(negedge clk);
  endtask

  // hold an ungranted request and keep at most one external access open
  task automatic drive_random_core();
    logic [31:0] r;
    word_t       a;
    r = $urandom;
    if (core_req && !last_gnt) begin
      core_req = 1'b1;
    end else if (ext_open || r[19:18] == 2'b00) begin
      core_req = 1'b0;
    end else begin
      if (r[1:0] != 2'b00) begin
        a = {RAM_REGION, r[6:2], 7'b0, r[11:7], r[12], 2'b00};
      end else begin
        a = $urandom;
        if (a[WORD_W-1 -: REGION_W] == RAM_REGION) a[WORD_W-1] = 1'b1;
      end
      core_req   = 1'b1;
      core_addr  = a;
      core_we    = r[13];
      core_be    = r[17:14];
      core_wdata = $urandom;
    end
  endtask

  // loader bursts of 1 to 4 cycles on the same small window
  task automatic drive_random_load();
    logic [31:0] r;
    r = $urandom;
    if (load_left == 0 && r[31:28] == 4'h0) load_left = $urandom_range(1, 4);
    if (load_left > 0) begin
      load_req   = 1'b1;
      load_word  = {7'b0, r[4:0]};
      load_we    = r[5];
      load_be    = r[13:6];
      load_wdata = {$urandom, $urandom};
      load_left--;
    end else begin
      load_req = 1'b0;
    end
  endtask

  task automatic wait_grant();
    int i;
    i = 0;
    run_cycle();
    while (!last_gnt) begin
      assert (i < WAIT_CYC) else fail_with_reason("timeout waiting for the core grant");
      run_cycle();
      i++;
    end
    core_req = 1'b0;
  endtask

  task automatic drain_responses();
    int i;
    i = 0;
    while (exp_is_ram.size() != 0) begin
      assert (i < WAIT_CYC) else fail_with_reason("timeout waiting for core responses");
      run_cycle();
      i++;
    end
  endtask

  task automatic core_access(word_t a, logic we, be_t be, word_t d);
    core_req   = 1'b1;
    core_addr  = a;
    core_we    = we;
    core_be    = be;
    core_wdata = d;
    wait_grant();
    drain_responses();
  endtask

  task automatic load_access(ram_word_t w, logic we, wide_be_t be, wide_t d);
    load_req   = 1'b1;
    load_word  = w;
    load_we    = we;
    load_be    = be;
    load_wdata = d;
    run_cycle();
    load_req = 1'b0;
    run_cycle();
  endtask

  initial begin
    int unsigned seed_val;
    seed_val = $urandom(SEED);
    rst_n = 1'b0;
    {core_req, core_addr, core_we, core_be, core_wdata} = '0;
    {load_req, load_word, load_we, load_be, load_wdata} = '0;
    {ext_gnt, ext_rvalid, ext_rdata} = '0;
    {cyc, n_done, load_left, last_gnt, ext_open, load_chk, slv_busy} = '0;
    slv_gnt_wait = $urandom_range(0, 3);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    // idle after reset
    repeat (4) run_cycle();
    // loader fills the whole RAM
    for (int w = 0; w < 2**RAM_WORDS_W; w++) begin
      load_req   = 1'b1;
      load_we    = 1'b1;
      load_be    = '1;
      load_word  = ram_word_t'(w);
      load_wdata = fill_word(ram_word_t'(w));
      run_cycle();
    end
    load_req = 1'b0;
    while (n_done < N_TRANS || (core_req && !last_gnt)) begin
      assert (cyc < MAX_CYC) else fail_with_reason("timeout in random traffic");
      drive_random_load();
      drive_random_core();
      run_cycle();
    end
    core_req = 1'b0;
    load_req = 1'b0;
    drain_responses();
    // loader word read through both core lanes and a core write seen by the loader
    load_access(12'h005, 1'b1, 8'hFF, 64'h1122_3344_5566_7788);
    core_access({RAM_REGION, 20'h0_0028}, 1'b0, 4'hF, 32'h0);
    core_access({RAM_REGION, 20'h0_002C}, 1'b0, 4'hF, 32'h0);
    core_access({RAM_REGION, 20'h0_002C}, 1'b1, 4'b0110, 32'hCAFE_F00D);
    load_access(12'h005, 1'b0, 8'h00, 64'h0);
    // core RAM read waits behind the loader
    core_req  = 1'b1;
    core_addr = {RAM_REGION, 20'h0_0010};
    core_we   = 1'b0;
    core_be   = '1;
    load_req  = 1'b1;
    load_we   = 1'b0;
    load_word = 12'h002;
    repeat (3) run_cycle();
    load_req = 1'b0;
    wait_grant();
    drain_responses();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/mem_region_pkg.sv
design/sp_ram.sv
design/ram_mux.sv
design/lsu_demux.sv
design/lsu_mem_region.sv
tb/lsu_mem_region_chk.sv
tb/tb_lsu_mem_region.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the data-memory region testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lsu_mem_region -f vlog.f -o tb_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qxF "Done: no errors" && exit 0 || { echo "simulation failed"; exit 1; }
